// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f vecdot.f \
		--top-module vecdot_tb -Mdir obj_dir -o vecdot_sim
	./obj_dir/vecdot_sim | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: rtl/dp4_lane.sv
`timescale 1ns/1ps
`default_nettype none

module dp4_lane (
    input  logic                    clk,
    input  logic                    reset,
    input  vecdot_pkg::elem_t [7:0] opnd,
    input  vecdot_pkg::rnd_t        rnd,
    output vecdot_pkg::elem_t       result,
    output logic                    sat
);

    localparam int KEEP_WIDTH = vecdot_pkg::SUM_WIDTH - vecdot_pkg::FRAC_BITS;
    localparam int RND_WIDTH  = KEEP_WIDTH + 1;
    localparam int HALF_BIT   = vecdot_pkg::FRAC_BITS - 1;
    localparam int TOP_BITS   = RND_WIDTH - vecdot_pkg::DATA_WIDTH + 1;

    logic signed [vecdot_pkg::PROD_WIDTH-1:0] prod_q [4];
    logic signed [vecdot_pkg::SUM_WIDTH-1:0]  sum_q;
    logic [KEEP_WIDTH-1:0]                    keep;
    logic [vecdot_pkg::FRAC_BITS-1:0]         frac;
    logic                                     incr;
    logic [RND_WIDTH-1:0]                     rounded;
    logic                                     ovf;
    vecdot_pkg::elem_t                        clipped;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stages 1 and 2: products, then their sum
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        for (int k = 0; k < 4; k++) begin
            prod_q[k] <= $signed(opnd[2*k]) * $signed(opnd[2*k+1]);
        end
        sum_q <= prod_q[0] + prod_q[1] + prod_q[2] + prod_q[3];
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 3: round away FRAC_BITS, then clip to the element range
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        // the kept bits are already the floor of the sum.
        keep = sum_q[vecdot_pkg::SUM_WIDTH-1:vecdot_pkg::FRAC_BITS];
        frac = sum_q[vecdot_pkg::FRAC_BITS-1:0];
        case (rnd)
            vecdot_pkg::RND_TRUNC:   incr = 1'b0;
            vecdot_pkg::RND_HALF_UP: incr = frac[HALF_BIT];
            default:                 incr = frac[HALF_BIT] & ((|frac[HALF_BIT-1:0]) | keep[0]);
        endcase
        rounded = {keep[KEEP_WIDTH-1], keep} + RND_WIDTH'(incr);
        ovf = rounded[RND_WIDTH-1:vecdot_pkg::DATA_WIDTH-1] != {TOP_BITS{rounded[RND_WIDTH-1]}};
        if (!ovf) begin
            clipped = rounded[vecdot_pkg::DATA_WIDTH-1:0];
        end else if (rounded[RND_WIDTH-1]) begin
            clipped = vecdot_pkg::ELEM_MIN;
        end else begin
            clipped = vecdot_pkg::ELEM_MAX;
        end
    end

    always_ff @(posedge clk) begin
        result <= clipped;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sat <= 1'b0;
        end else begin
            sat <= ovf;
        end
    end

    // a clipped result must sit on one of the two range limits.
    assert property (@(posedge clk) disable iff (reset)
        sat |-> (result == vecdot_pkg::ELEM_MAX || result == vecdot_pkg::ELEM_MIN));

endmodule

`default_nettype wire

// File: rtl/dp_operand_router.sv
`timescale 1ns/1ps
`default_nettype none

module dp_operand_router (
    input  vecdot_pkg::funct_t                                    funct,
    input  vecdot_pkg::elem_t [vecdot_pkg::VECTOR_LANES-1:0]      vec_a,
    input  vecdot_pkg::elem_t [vecdot_pkg::VECTOR_LANES-1:0]      vec_b,
    input  vecdot_pkg::elem_t [vecdot_pkg::VECTOR_LANES-1:0]      vec_c,
    output vecdot_pkg::elem_t [vecdot_pkg::VECTOR_LANES-1:0][7:0] opnd
);

    typedef vecdot_pkg::elem_t [7:0] pairs_t;

    // quaternion components of vec_a and their negated copies.
    vecdot_pkg::elem_t qw, qx, qy, qz;
    vecdot_pkg::elem_t nw, nx, ny, nz;

    // operand 2k is multiplied by operand 2k+1.
    function automatic pairs_t pairs(input vecdot_pkg::elem_t a0, b0, a1, b1,
                                     input vecdot_pkg::elem_t a2, b2, a3, b3);
        return {b3, a3, b2, a2, b1, a1, b0, a0};
    endfunction

    // -ELEM_MIN has no Q16.16 encoding, so it clips to ELEM_MAX.
    function automatic vecdot_pkg::elem_t sat_neg(input vecdot_pkg::elem_t v);
        return (v == vecdot_pkg::ELEM_MIN) ? vecdot_pkg::ELEM_MAX : -v;
    endfunction

    assign {qz, qy, qx, qw} = vec_a[3:0];
    assign nw = sat_neg(qw);
    assign nx = sat_neg(qx);
    assign ny = sat_neg(qy);
    assign nz = sat_neg(qz);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand selection per function code
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        opnd = '0;
        case (funct)
            vecdot_pkg::FUNCT_MAT: begin
                // column i of b times the 3x3 a, plus c.
                for (int i = 0; i < 3; i++) begin
                    for (int j = 0; j < 3; j++) begin
                        opnd[3*i+j] = pairs(vec_a[j], vec_b[3*i],
                                            vec_a[3+j], vec_b[3*i+1],
                                            vec_a[6+j], vec_b[3*i+2],
                                            vec_c[3*i+j], vecdot_pkg::ELEM_ONE);
                    end
                end
            end
            vecdot_pkg::FUNCT_DOT: begin
                for (int g = 0; g < vecdot_pkg::VECTOR_LANES / 4; g++) begin
                    opnd[4*g] = pairs(vec_a[4*g], vec_b[4*g],
                                      vec_a[4*g+1], vec_b[4*g+1],
                                      vec_a[4*g+2], vec_b[4*g+2],
                                      vec_a[4*g+3], vec_b[4*g+3]);
                end
            end
            vecdot_pkg::FUNCT_QMUL: begin
                // Hamilton product, the result w x y z in lanes 0 to 3.
                opnd[0] = pairs(qw, vec_b[0], nx, vec_b[1], ny, vec_b[2], nz, vec_b[3]);
                opnd[1] = pairs(qw, vec_b[1], qx, vec_b[0], qy, vec_b[3], nz, vec_b[2]);
                opnd[2] = pairs(qw, vec_b[2], nx, vec_b[3], qy, vec_b[0], qz, vec_b[1]);
                opnd[3] = pairs(qw, vec_b[3], qx, vec_b[2], ny, vec_b[1], qz, vec_b[0]);
            end
            vecdot_pkg::FUNCT_ROT: begin
                // row-major 3x3, the doubled terms written as two equal products.
                opnd[0] = pairs(qw, qw, qx, qx, ny, qy, nz, qz);
                opnd[1] = pairs(qx, qy, qx, qy, nw, qz, nw, qz);
                opnd[2] = pairs(qx, qz, qx, qz, qw, qy, qw, qy);
                opnd[3] = pairs(qx, qy, qx, qy, qw, qz, qw, qz);
                opnd[4] = pairs(qw, qw, nx, qx, qy, qy, nz, qz);
                opnd[5] = pairs(qy, qz, qy, qz, nw, qx, nw, qx);
                opnd[6] = pairs(qx, qz, qx, qz, nw, qy, nw, qy);
                opnd[7] = pairs(qy, qz, qy, qz, qw, qx, qw, qx);
                opnd[8] = pairs(qw, qw, nx, qx, ny, qy, qz, qz);
            end
            default: opnd = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/vecdot_config.sv
`timescale 1ns/1ps
`default_nettype none

module vecdot_config (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                cfg_write,
    input  vecdot_pkg::funct_t                  cfg_funct,
    input  vecdot_pkg::rnd_t                    cfg_rnd,
    input  logic [vecdot_pkg::VECTOR_LANES-1:0] sat,
    output vecdot_pkg::funct_t                  funct,
    output vecdot_pkg::rnd_t                    rnd,
    output logic [vecdot_pkg::VECTOR_LANES-1:0] sat_status
);

    // a write starts a fresh saturation record for the new mode.
    always_ff @(posedge clk) begin
        if (reset) begin
            funct      <= vecdot_pkg::FUNCT_MAT;
            rnd        <= vecdot_pkg::RND_TRUNC;
            sat_status <= '0;
        end else if (cfg_write) begin
            funct      <= cfg_funct;
            rnd        <= cfg_rnd;
            sat_status <= '0;
        end else begin
            sat_status <= sat_status | sat;
        end
    end

    // the router steers every lane from funct, so it must stay known.
    assert property (@(posedge clk) disable iff (reset) !$isunknown(funct));

endmodule

`default_nettype wire

// File: rtl/vecdot_pkg.sv
`default_nettype none

package vecdot_pkg;

    localparam int VECTOR_LANES = 16;
    localparam int DATA_WIDTH   = 32;
    localparam int FRAC_BITS    = 16;
    localparam int NUM_STAGES   = 3;
    localparam int PROD_WIDTH   = 2 * DATA_WIDTH;
    // two guard bits cover the carry out of a four-term sum.
    localparam int SUM_WIDTH    = PROD_WIDTH + 2;

    // one signed Q16.16 element.
    typedef logic [DATA_WIDTH-1:0] elem_t;

    typedef logic [2:0] funct_t;
    localparam funct_t FUNCT_MAT  = 3'd0;
    localparam funct_t FUNCT_DOT  = 3'd1;
    localparam funct_t FUNCT_QMUL = 3'd2;
    localparam funct_t FUNCT_ROT  = 3'd3;

    typedef logic [1:0] rnd_t;
    localparam rnd_t RND_TRUNC   = 2'd0;
    localparam rnd_t RND_HALF_UP = 2'd1;
    localparam rnd_t RND_EVEN    = 2'd2;

    localparam elem_t ELEM_ONE = 32'h0001_0000;
    localparam elem_t ELEM_MAX = 32'h7fff_ffff;
    localparam elem_t ELEM_MIN = 32'h8000_0000;

endpackage

`default_nettype wire

// File: rtl/vecdot_unit.sv
`timescale 1ns/1ps
`default_nettype none

module vecdot_unit (
    input  logic                                               clk,
    input  logic                                               reset,
    input  logic                                               en,
    input  logic                                               cfg_write,
    input  vecdot_pkg::funct_t                                 cfg_funct,
    input  vecdot_pkg::rnd_t                                   cfg_rnd,
    input  vecdot_pkg::elem_t [vecdot_pkg::VECTOR_LANES-1:0]   vec_a,
    input  vecdot_pkg::elem_t [vecdot_pkg::VECTOR_LANES-1:0]   vec_b,
    input  vecdot_pkg::elem_t [vecdot_pkg::VECTOR_LANES-1:0]   vec_c,
    output vecdot_pkg::elem_t [vecdot_pkg::VECTOR_LANES-1:0]   vec_out,
    output logic                                               out_valid,
    output logic [vecdot_pkg::VECTOR_LANES-1:0]                sat_status
);

    vecdot_pkg::funct_t                                    funct;
    vecdot_pkg::rnd_t                                      rnd;
    vecdot_pkg::elem_t [vecdot_pkg::VECTOR_LANES-1:0][7:0] opnd;
    vecdot_pkg::elem_t [vecdot_pkg::VECTOR_LANES-1:0]      lane_result;
    vecdot_pkg::elem_t [vecdot_pkg::VECTOR_LANES-1:0]      held_q;
    logic [vecdot_pkg::VECTOR_LANES-1:0]                   lane_sat;
    logic [vecdot_pkg::NUM_STAGES-1:0]                     valid_q;

    vecdot_config u_config (
        .clk        (clk),
        .reset      (reset),
        .cfg_write  (cfg_write),
        .cfg_funct  (cfg_funct),
        .cfg_rnd    (cfg_rnd),
        .sat        (lane_sat),
        .funct      (funct),
        .rnd        (rnd),
        .sat_status (sat_status)
    );

    dp_operand_router u_router (
        .funct (funct),
        .vec_a (vec_a),
        .vec_b (vec_b),
        .vec_c (vec_c),
        .opnd  (opnd)
    );

    for (genvar l = 0; l < vecdot_pkg::VECTOR_LANES; l++) begin : g_lane
        dp4_lane u_lane (
            .clk    (clk),
            .reset  (reset),
            .opnd   (opnd[l]),
            .rnd    (rnd),
            .result (lane_result[l]),
            .sat    (lane_sat[l])
        );
    end

    // en rides alongside the lane pipeline, one bit per stage.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[vecdot_pkg::NUM_STAGES-2:0], en};
        end
    end

    assign out_valid = valid_q[vecdot_pkg::NUM_STAGES-1];

    // lanes reload every cycle, so the last valid result is kept here.
    always_ff @(posedge clk) begin
        held_q <= vec_out;
    end

    assign vec_out = out_valid ? lane_result : held_q;

    assert property (@(posedge clk) disable iff (reset)
        en |-> ##(vecdot_pkg::NUM_STAGES) out_valid);

endmodule

`default_nettype wire

// File: vecdot.f
+incdir+include
rtl/vecdot_pkg.sv
rtl/dp_operand_router.sv
rtl/dp4_lane.sv
rtl/vecdot_config.sv
rtl/vecdot_unit.sv
verif/vecdot_tb.sv

// File: include/vecdot_ref.svh
`ifndef VECDOT_REF_SVH
`define VECDOT_REF_SVH

typedef vecdot_pkg::elem_t [vecdot_pkg::VECTOR_LANES-1:0] ref_vec_t;
typedef logic [vecdot_pkg::VECTOR_LANES-1:0]              ref_mask_t;

// negation clips -ELEM_MIN to ELEM_MAX, the same as the datapath.
function automatic vecdot_pkg::elem_t ref_neg(input vecdot_pkg::elem_t v);
    return (v == vecdot_pkg::ELEM_MIN) ? vecdot_pkg::ELEM_MAX : -v;
endfunction

function automatic longint ref_mul(input vecdot_pkg::elem_t a, b);
    return longint'($signed(a)) * longint'($signed(b));
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one lane: four products, rounding, saturation; returns {sat, value}
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

function automatic logic [32:0] ref_lane(input vecdot_pkg::elem_t a0, b0, a1, b1,
                                         input vecdot_pkg::elem_t a2, b2, a3, b3,
                                         input vecdot_pkg::rnd_t rnd);
    logic signed [vecdot_pkg::SUM_WIDTH-1:0] sum;
    logic signed [vecdot_pkg::SUM_WIDTH-1:0] keep;
    logic [15:0]                             frac;
    logic signed [vecdot_pkg::SUM_WIDTH-1:0] r;
    sum  = ref_mul(a0, b0) + ref_mul(a1, b1) + ref_mul(a2, b2) + ref_mul(a3, b3);
    keep = sum >>> vecdot_pkg::FRAC_BITS;
    frac = sum[15:0];
    case (rnd)
        vecdot_pkg::RND_TRUNC:   r = keep;
        vecdot_pkg::RND_HALF_UP: r = keep + frac[15];
        default:                 r = keep + (frac[15] && (frac[14:0] != 0 || keep[0]));
    endcase
    if (r > 66'sd2147483647) begin
        return {1'b1, vecdot_pkg::ELEM_MAX};
    end
    if (r < -66'sd2147483648) begin
        return {1'b1, vecdot_pkg::ELEM_MIN};
    end
    return {1'b0, r[31:0]};
endfunction

function automatic void ref_mat(input ref_vec_t a, b, c, input vecdot_pkg::rnd_t rnd,
                                output ref_vec_t res, output ref_mask_t sat);
    res = '0;
    sat = '0;
    for (int i = 0; i < 3; i++) begin
        for (int j = 0; j < 3; j++) begin
            {sat[3*i+j], res[3*i+j]} = ref_lane(a[j], b[3*i], a[3+j], b[3*i+1], a[6+j],
                                                b[3*i+2], c[3*i+j], vecdot_pkg::ELEM_ONE, rnd);
        end
    end
endfunction

function automatic void ref_dot(input ref_vec_t a, b, input vecdot_pkg::rnd_t rnd,
                                output ref_vec_t res, output ref_mask_t sat);
    res = '0;
    sat = '0;
    for (int g = 0; g < vecdot_pkg::VECTOR_LANES / 4; g++) begin
        {sat[4*g], res[4*g]} = ref_lane(a[4*g], b[4*g], a[4*g+1], b[4*g+1],
                                        a[4*g+2], b[4*g+2], a[4*g+3], b[4*g+3], rnd);
    end
endfunction

function automatic void ref_qmul(input ref_vec_t a, b, input vecdot_pkg::rnd_t rnd,
                                 output ref_vec_t res, output ref_mask_t sat);
    res = '0;
    sat = '0;
    {sat[0], res[0]} = ref_lane(a[0], b[0], ref_neg(a[1]), b[1],
                                ref_neg(a[2]), b[2], ref_neg(a[3]), b[3], rnd);
    {sat[1], res[1]} = ref_lane(a[0], b[1], a[1], b[0], a[2], b[3], ref_neg(a[3]), b[2], rnd);
    {sat[2], res[2]} = ref_lane(a[0], b[2], ref_neg(a[1]), b[3], a[2], b[0], a[3], b[1], rnd);
    {sat[3], res[3]} = ref_lane(a[0], b[3], a[1], b[2], ref_neg(a[2]), b[1], a[3], b[0], rnd);
endfunction

function automatic void ref_rot(input ref_vec_t a, input vecdot_pkg::rnd_t rnd,
                                output ref_vec_t res, output ref_mask_t sat);
    vecdot_pkg::elem_t w, x, y, z;
    w   = a[0];
    x   = a[1];
    y   = a[2];
    z   = a[3];
    res = '0;
    sat = '0;
    {sat[0], res[0]} = ref_lane(w, w, x, x, ref_neg(y), y, ref_neg(z), z, rnd);
    {sat[1], res[1]} = ref_lane(x, y, x, y, ref_neg(w), z, ref_neg(w), z, rnd);
    {sat[2], res[2]} = ref_lane(x, z, x, z, w, y, w, y, rnd);
    {sat[3], res[3]} = ref_lane(x, y, x, y, w, z, w, z, rnd);
    {sat[4], res[4]} = ref_lane(w, w, ref_neg(x), x, y, y, ref_neg(z), z, rnd);
    {sat[5], res[5]} = ref_lane(y, z, y, z, ref_neg(w), x, ref_neg(w), x, rnd);
    {sat[6], res[6]} = ref_lane(x, z, x, z, ref_neg(w), y, ref_neg(w), y, rnd);
    {sat[7], res[7]} = ref_lane(y, z, y, z, w, x, w, x, rnd);
    {sat[8], res[8]} = ref_lane(w, w, ref_neg(x), x, ref_neg(y), y, z, z, rnd);
endfunction

`endif

// File: verif/vecdot_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vecdot_tb;

    `include "vecdot_ref.svh"

    localparam int MAT_OPS     = 40;
    localparam int RAND_OPS    = 12;
    localparam int ZERO_OPS    = 4;
    localparam int RND_OPS     = 4;
    localparam int SAT_OPS     = 6;
    localparam int TOTAL_OPS   = 1 + MAT_OPS + 3 * RAND_OPS + ZERO_OPS + 3 * RND_OPS + SAT_OPS;
    localparam int CYCLE_LIMIT = 2 * TOTAL_OPS + 200;

    logic               clk = 1'b0;
    logic               reset;
    logic               en;
    logic               cfg_write;
    vecdot_pkg::funct_t cfg_funct;
    vecdot_pkg::rnd_t   cfg_rnd;
    ref_vec_t           vec_a;
    ref_vec_t           vec_b;
    ref_vec_t           vec_c;
    ref_vec_t           vec_out;
    logic               out_valid;
    ref_mask_t          sat_status;

    vecdot_pkg::funct_t cur_funct = vecdot_pkg::FUNCT_MAT;
    vecdot_pkg::rnd_t   cur_rnd = vecdot_pkg::RND_TRUNC;
    ref_vec_t           exp_q[$];
    ref_vec_t           popped;
    ref_vec_t           last_exp;
    ref_mask_t          exp_sat = '0;
    int                 errors = 0;
    int                 checks = 0;
    int                 ops_issued = 0;
    int                 test_err_start = 0;
    int                 cycle_count = 0;

    vecdot_unit uut (
        .clk        (clk),
        .reset      (reset),
        .en         (en),
        .cfg_write  (cfg_write),
        .cfg_funct  (cfg_funct),
        .cfg_rnd    (cfg_rnd),
        .vec_a      (vec_a),
        .vec_b      (vec_b),
        .vec_c      (vec_c),
        .vec_out    (vec_out),
        .out_valid  (out_valid),
        .sat_status (sat_status)
    );

    always #10 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // expected values and checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic void expect_for(input vecdot_pkg::funct_t f, input vecdot_pkg::rnd_t r,
                                       input ref_vec_t a, b, c,
                                       output ref_vec_t res, output ref_mask_t mask);
        case (f)
            vecdot_pkg::FUNCT_MAT:  ref_mat(a, b, c, r, res, mask);
            vecdot_pkg::FUNCT_DOT:  ref_dot(a, b, r, res, mask);
            vecdot_pkg::FUNCT_QMUL: ref_qmul(a, b, r, res, mask);
            vecdot_pkg::FUNCT_ROT:  ref_rot(a, r, res, mask);
            default: begin
                res  = '0;
                mask = '0;
            end
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // results are read at the falling edge half a cycle after they settle.
    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("error at %0t: out_valid with no operation outstanding", $time);
                errors++;
            end else begin
                popped = exp_q.pop_front();
                for (int l = 0; l < vecdot_pkg::VECTOR_LANES; l++) begin
                    check_value($sformatf("vec_out[%0d]", l), vec_out[l], popped[l]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // roughly -4.0 to 4.0 with a random fraction.
    function automatic vecdot_pkg::elem_t small_elem();
        logic signed [31:0] r;
        r = $urandom;
        return r >>> 13;
    endfunction

    function automatic ref_vec_t small_vec();
        ref_vec_t v;
        for (int l = 0; l < vecdot_pkg::VECTOR_LANES; l++) begin
            v[l] = small_elem();
        end
        return v;
    endfunction

    function automatic ref_vec_t full_vec();
        ref_vec_t v;
        for (int l = 0; l < vecdot_pkg::VECTOR_LANES; l++) begin
            v[l] = $urandom;
        end
        return v;
    endfunction

    task automatic issue_op(input ref_vec_t a, b, c);
        ref_vec_t  res;
        ref_mask_t mask;
        expect_for(cur_funct, cur_rnd, a, b, c, res, mask);
        exp_q.push_back(res);
        last_exp = res;
        exp_sat = exp_sat | mask;
        ops_issued++;
        @(posedge clk);
        en    <= 1'b1;
        vec_a <= a;
        vec_b <= b;
        vec_c <= c;
    endtask

    // the last result is due a few cycles after en drops.
    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        en <= 1'b0;
        while (exp_q.size() != 0 && waited < 2 * vecdot_pkg::NUM_STAGES) begin
            @(posedge clk);
            waited++;
        end
        repeat (2) @(posedge clk);
    endtask

    // only called with the pipeline empty, so funct never changes under an operation.
    task automatic set_config(input vecdot_pkg::funct_t f, input vecdot_pkg::rnd_t r);
        @(posedge clk);
        cfg_write <= 1'b1;
        cfg_funct <= f;
        cfg_rnd   <= r;
        @(posedge clk);
        cfg_write <= 1'b0;
        cur_funct = f;
        cur_rnd   = r;
        exp_sat   = '0;
    endtask

    task automatic end_test(input string name);
        $display("test %s: %s (%0d errors)", name,
                 (errors == test_err_start) ? "ok" : "FAILED", errors - test_err_start);
        test_err_start = errors;
    endtask

    // four odd raw values give a dropped half with odd and even kept bits.
    task automatic rounding_ops(input vecdot_pkg::rnd_t r);
        ref_vec_t a;
        ref_vec_t b;
        logic signed [31:0] x;
        set_config(vecdot_pkg::FUNCT_DOT, r);
        for (int k = 0; k < RND_OPS; k++) begin
            a = '0;
            b = '0;
            for (int g = 0; g < 4; g++) begin
                x = $urandom;
                x = (x >>> 8) | 32'sd1;
                if (k == 0) begin
                    x = (g == 0) ? 5 : (g == 1) ? 7 : (g == 2) ? -5 : -7;
                end
                a[4*g] = x;
                b[4*g] = 32'h0000_8000;
            end
            issue_op(a, b, '0);
        end
        drain();
    endtask

    initial begin
        ref_vec_t a;
        ref_vec_t b;
        int       lat;
        void'($urandom(32'h58d0_783c));
        reset     = 1'b1;
        en        = 1'b0;
        cfg_write = 1'b0;
        cfg_funct = vecdot_pkg::FUNCT_MAT;
        cfg_rnd   = vecdot_pkg::RND_TRUNC;
        vec_a     = '0;
        vec_b     = '0;
        vec_c     = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("out_valid", out_valid, 0);
        check_value("sat_status", sat_status, 0);

        // a single pulse under the reset mode is timed.
        // new operands follow with en low, and the output must keep the old result.
        issue_op(small_vec(), small_vec(), small_vec());
        @(posedge clk);
        en    <= 1'b0;
        vec_a <= small_vec();
        vec_b <= small_vec();
        vec_c <= small_vec();
        lat = 1;
        @(negedge clk);
        while (!out_valid && lat < 8) begin
            @(negedge clk);
            lat++;
        end
        check_value("out_valid latency", lat, 3);
        @(negedge clk);
        check_value("out_valid", out_valid, 0);
        check_value("vec_out[0] held", vec_out[0], last_exp[0]);
        drain();
        end_test("reset and latency");

        set_config(vecdot_pkg::FUNCT_MAT, vecdot_pkg::RND_EVEN);
        for (int k = 0; k < MAT_OPS; k++) begin
            issue_op(small_vec(), small_vec(), small_vec());
        end
        drain();
        end_test("matrix back to back");

        set_config(vecdot_pkg::FUNCT_DOT, vecdot_pkg::RND_EVEN);
        for (int k = 0; k < RAND_OPS; k++) begin
            issue_op(small_vec(), small_vec(), small_vec());
        end
        drain();
        set_config(vecdot_pkg::FUNCT_QMUL, vecdot_pkg::RND_HALF_UP);
        for (int k = 0; k < RAND_OPS; k++) begin
            issue_op(small_vec(), small_vec(), small_vec());
        end
        drain();
        set_config(vecdot_pkg::FUNCT_ROT, vecdot_pkg::RND_TRUNC);
        for (int k = 0; k < RAND_OPS; k++) begin
            issue_op(small_vec(), small_vec(), small_vec());
        end
        drain();
        set_config(3'd5, vecdot_pkg::RND_EVEN);
        for (int k = 0; k < ZERO_OPS; k++) begin
            issue_op(full_vec(), full_vec(), full_vec());
        end
        drain();
        end_test("dot qmul rot and unused code");

        rounding_ops(vecdot_pkg::RND_TRUNC);
        rounding_ops(vecdot_pkg::RND_HALF_UP);
        rounding_ops(vecdot_pkg::RND_EVEN);
        end_test("rounding");

        // lanes 0 and 12 clip high, lane 4 clips low, lane 8 stays in range.
        set_config(vecdot_pkg::FUNCT_DOT, vecdot_pkg::RND_HALF_UP);
        a = '0;
        b = '0;
        a[0] = 32'h7fff_0000;
        b[0] = 32'h7fff_0000;
        a[4] = 32'h7fff_0000;
        b[4] = vecdot_pkg::ELEM_MIN;
        a[8] = vecdot_pkg::ELEM_ONE;
        b[8] = vecdot_pkg::ELEM_ONE;
        for (int l = 12; l < 16; l++) begin
            a[l] = vecdot_pkg::ELEM_MIN;
            b[l] = vecdot_pkg::ELEM_MIN;
        end
        issue_op(a, b, '0);
        // in-range operations follow, so only the sticky record keeps the clipped lanes.
        for (int k = 1; k < SAT_OPS; k++) begin
            issue_op(small_vec(), small_vec(), small_vec());
        end
        drain();
        @(negedge clk);
        check_value("sat_status", sat_status, exp_sat);
        set_config(vecdot_pkg::FUNCT_DOT, vecdot_pkg::RND_EVEN);
        @(negedge clk);
        check_value("sat_status", sat_status, 0);
        end_test("saturation");

        if (exp_q.size() != 0) begin
            $display("error: %0d results never came out of the DUT", exp_q.size());
            errors++;
        end
        $display("checks %0d, operations %0d, errors %0d", checks, ops_issued, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
